//--- Makefile
VERILATOR ?= verilator
TOP       = stream_switch_tb
FILELIST  = sources.f
BUILD_DIR = obj_dir
VFLAGS    = --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(BUILD_DIR)
LINTFLAGS = --lint-only --timing --top-module $(TOP)
RUNFLAGS  = +verilator+error+limit+1000
PASS_MSG  = *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUNFLAGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- bench/stream_switch_asserts.sv
// stream switch checker: output stability under stall and post-reset state
`timescale 1ns/1ps

module stream_switch_asserts (
    input logic                                                 clk,
    input logic                                                 rst,
    input stream_pkg::stream_beat_t [stream_pkg::num_ports-1:0] m_beat,
    input logic [stream_pkg::num_ports-1:0]                     m_valid,
    input logic [stream_pkg::num_ports-1:0]                     m_ready,
    input logic                                                 s_ready
);

    int fail_count;

    initial fail_count = 0;

    // a stalled output keeps its beat and its valid
    for (genvar i = 0; i < stream_pkg::num_ports; i++) begin : g_port
        hold_stalled_beat: assert property (@(posedge clk) disable iff (rst)
            m_valid[i] && !m_ready[i] |=> m_valid[i] && $stable(m_beat[i]))
        else begin
            $error("port %0d output beat changed while stalled", i);
            fail_count++;
        end
    end

    // outputs idle and input open right after reset
    reset_clears_valid: assert property (@(posedge clk) rst |=> m_valid == '0)
    else begin
        $error("m_valid not cleared after reset");
        fail_count++;
    end

    reset_opens_input: assert property (@(posedge clk) rst |=> s_ready)
    else begin
        $error("s_ready low after reset");
        fail_count++;
    end

endmodule

bind stream_switch_top stream_switch_asserts u_asserts (
    .clk     (clk),
    .rst     (rst),
    .m_beat  (m_beat),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .s_ready (s_ready)
);

//--- bench/stream_switch_tb.sv
// stream switch testbench with file-driven frames, random output stalls and per-port scoreboards
`timescale 1ns/1ps

module stream_switch_tb;

    localparam int ready_timeout = 2000;
    localparam int drain_timeout = 2000;

    logic                                                 clk;
    logic                                                 rst;
    stream_pkg::stream_beat_t                             s_beat;
    logic                                                 s_valid;
    logic                                                 s_ready;
    stream_pkg::stream_beat_t [stream_pkg::num_ports-1:0] m_beat;
    logic [stream_pkg::num_ports-1:0]                     m_valid;
    logic [stream_pkg::num_ports-1:0]                     m_ready;

    // expected beats and their frame names kept in one queue per port
    stream_pkg::stream_beat_t exp_q [stream_pkg::num_ports][$];
    string                    name_q [stream_pkg::num_ports][$];
    logic [7:0]               payload_q [$];

    integer seed;
    int     fd;
    logic   timed_out;
    int     mismatch_count;
    int     unexpected_count;
    int     missing_count;
    int     timeout_count;
    int     setup_count;
    int     assert_count;
    int     total_errors;

    stream_switch_top u_stream_switch_top (
        .clk     (clk),
        .rst     (rst),
        .s_beat  (s_beat),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .m_beat  (m_beat),
        .m_valid (m_valid),
        .m_ready (m_ready)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // random back-pressure with each port ready about one cycle in eight
    // so the FIFOs fill and the demux skid register comes into play
    initial begin
        int rnd;
        m_ready = '0;
        forever begin
            @(posedge clk);
            #1;
            rnd = $random(seed);
            for (int p = 0; p < stream_pkg::num_ports; p++) begin
                m_ready[p] = (rnd[3*p +: 3] == 3'b000);
            end
        end
    end

    function automatic int pending_beats();
        int sum;
        sum = 0;
        for (int p = 0; p < stream_pkg::num_ports; p++) begin
            sum += exp_q[p].size();
        end
        return sum;
    endfunction

    function automatic void check_output(int port, stream_pkg::stream_beat_t got);
        stream_pkg::stream_beat_t exp;
        string                    name;
        assert (exp_q[port].size() != 0) else begin
            $display("port %0d delivered beat %h while no frame was pending", port, got);
            unexpected_count++;
        end
        if (exp_q[port].size() != 0) begin
            exp  = exp_q[port].pop_front();
            name = name_q[port].pop_front();
            assert (got == exp) else begin
                $write("Fail %s port %0d expected data %h last %b user %b",
                       name, port, exp.data, exp.last, exp.user);
                $display(" actual data %h last %b user %b", got.data, got.last, got.user);
                mismatch_count++;
            end
        end
    endfunction

    // outputs are sampled mid-cycle and transfer at the next rising edge
    always @(negedge clk) begin
        if (!rst) begin
            for (int p = 0; p < stream_pkg::num_ports; p++) begin
                if (m_valid[p] && m_ready[p]) begin
                    check_output(p, m_beat[p]);
                end
            end
        end
    end

    // holds the beat until s_ready is seen and returns just after a rising edge
    task automatic drive_beat(input stream_pkg::stream_beat_t beat, input string name);
        int   waited;
        logic accepted;
        s_beat   = beat;
        s_valid  = 1'b1;
        waited   = 0;
        accepted = 1'b0;
        while (!accepted && !timed_out) begin
            @(negedge clk);
            accepted = s_ready;
            @(posedge clk);
            #1;
            if (!accepted) begin
                waited++;
                if (waited >= ready_timeout) begin
                    $display("input stalled, s_ready low for %0d cycles in %s", waited, name);
                    timeout_count++;
                    timed_out = 1'b1;
                end
            end
        end
    endtask

    task automatic send_frame(input string name, input logic [7:0] hdr, input string exp_tok);
        int                       n;
        int                       file_dest;
        int                       rule_dest;
        stream_pkg::stream_beat_t beat;
        n         = payload_q.size();
        file_dest = (exp_tok == "-") ? -1 : exp_tok.atoi();
        // drop bit or an empty payload means nothing comes out
        rule_dest = (hdr[stream_pkg::hdr_drop_bit] || n == 0) ? -1 : int'(hdr[1:0]);
        assert (file_dest == rule_dest) else begin
            $display("Fail %s expected port %0d actual port %0d in test file",
                     name, rule_dest, file_dest);
            setup_count++;
        end
        if (rule_dest >= 0) begin
            for (int k = 0; k < n; k++) begin
                beat.data = payload_q[k];
                beat.last = (k == n - 1);
                beat.user = k[0];
                exp_q[rule_dest].push_back(beat);
                name_q[rule_dest].push_back(name);
            end
        end
        beat.data = hdr;
        beat.last = (n == 0);
        beat.user = 1'b1;
        drive_beat(beat, name);
        for (int k = 0; k < n && !timed_out; k++) begin
            beat.data = payload_q[k];
            beat.last = (k == n - 1);
            beat.user = k[0];
            drive_beat(beat, name);
        end
    endtask

    task automatic run_tests();
        string name;
        string tok;
        string line;
        int    hdr_val;
        int    n;
        int    val;
        int    code;
        while (!timed_out) begin
            code = $fscanf(fd, "%s", name);
            if (code != 1) begin
                break;
            end
            // '#' opens a comment line
            if (name.getc(0) == 8'h23) begin
                code = $fgets(line, fd);
                continue;
            end
            code = $fscanf(fd, "%h %d", hdr_val, n);
            payload_q.delete();
            for (int k = 0; k < n; k++) begin
                code = $fscanf(fd, "%h", val);
                payload_q.push_back(val[7:0]);
            end
            code = $fscanf(fd, "%s", tok);
            send_frame(name, hdr_val[7:0], tok);
        end
    endtask

    task automatic drain_outputs();
        int waited;
        waited = 0;
        while (pending_beats() != 0 && waited < drain_timeout) begin
            @(posedge clk);
            waited++;
        end
        if (pending_beats() != 0) begin
            $display("drain timed out with %0d beats never delivered", pending_beats());
            missing_count += pending_beats();
            timeout_count++;
        end else begin
            @(negedge clk);
            assert (m_valid == '0) else begin
                $display("Fail drain_idle expected m_valid %b actual %b", 4'b0000, m_valid);
                unexpected_count++;
            end
        end
    endtask

    initial begin
        seed             = 32'hb68a_247d;
        rst              = 1'b1;
        s_beat           = '0;
        s_valid          = 1'b0;
        timed_out        = 1'b0;
        mismatch_count   = 0;
        unexpected_count = 0;
        missing_count    = 0;
        timeout_count    = 0;
        setup_count      = 0;

        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        @(negedge clk);
        assert (m_valid == '0) else begin
            $display("Fail reset_state expected m_valid %b actual %b", 4'b0000, m_valid);
            mismatch_count++;
        end
        assert (s_ready == 1'b1) else begin
            $display("Fail reset_state expected s_ready %b actual %b", 1'b1, s_ready);
            mismatch_count++;
        end
        @(posedge clk);
        #1;

        fd = $fopen("bench/stream_switch_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open bench/stream_switch_tests.txt");
            setup_count++;
        end else begin
            run_tests();
            $fclose(fd);
        end
        s_valid = 1'b0;

        if (!timed_out) begin
            drain_outputs();
        end

        assert_count = u_stream_switch_top.u_asserts.fail_count;
        total_errors = mismatch_count + unexpected_count + missing_count +
                       timeout_count + setup_count + assert_count;
        $write("errors: %0d mismatched, %0d unexpected, %0d missing, ",
               mismatch_count, unexpected_count, missing_count);
        $display("%0d timeouts, %0d setup, %0d assertions",
                 timeout_count, setup_count, assert_count);
        if (total_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- bench/stream_switch_tests.txt
# name header_hex payload_count payload_bytes_hex... expected_port (- means no output)
# header bit 7 drops the frame, bits 1:0 select the port, bits 6:2 are ignored
route_p0 00 3 10 11 12 0
route_p1 01 4 20 21 22 23 1
route_p2 02 2 30 31 2
route_p3 03 5 40 41 42 43 44 3
ignored_bits_p1 7d 3 55 56 57 1
ignored_bits_p2 46 2 66 67 2
ignored_bits_p3 2f 2 7a 7b 3
drop_p1 81 4 a0 a1 a2 a3 -
after_drop_p1 01 2 b0 b1 1
drop_high_bits ff 3 c0 c1 c2 -
hdr_only_p2 02 0 -
after_hdr_only_p2 02 3 d0 d1 d2 2
hdr_only_drop 83 0 -
single_byte_p3 03 1 e5 3
burst_p0_a 00 6 01 02 03 04 05 06 0
burst_p0_b 00 5 07 08 09 0a 0b 0
burst_p3 03 4 f0 f1 f2 f3 3
burst_p1 01 7 81 82 83 84 85 86 87 1
burst_p2 02 9 90 91 92 93 94 95 96 97 98 2
drop_p0 80 2 ee ef -
final_p0 00 3 fd fe ff 0

//--- design/axis_demux_4.sv
// four-port frame demultiplexer with a registered output stage and one skid register
`timescale 1ns/1ps

module axis_demux_4 (
    input  logic                              clk,
    input  logic                              rst,
    input  stream_pkg::stream_beat_t          in_beat,
    input  logic                              in_valid,
    output logic                              in_ready,
    output stream_pkg::stream_beat_t          out_beat,
    output logic [stream_pkg::num_ports-1:0]  out_valid,
    input  logic [stream_pkg::num_ports-1:0]  out_ready,
    input  logic                              route_en,
    input  stream_pkg::port_sel_t             route_sel
);

    // frame tracking and latched selection
    stream_pkg::port_sel_t select_reg;
    stream_pkg::port_sel_t select_next;
    logic                  frame_reg;
    logic                  frame_next;
    logic                  in_ready_reg;
    logic                  in_ready_next;

    // handoff from the input side to the output stage
    logic                  int_valid;
    logic                  int_ready_reg;
    logic                  int_ready_early;

    // output register shared by all ports, valid kept per port
    stream_pkg::stream_beat_t             out_beat_reg;
    logic [stream_pkg::num_ports-1:0]     out_valid_reg;
    logic [stream_pkg::num_ports-1:0]     out_valid_next;

    // skid register for a beat accepted while the output stalls
    stream_pkg::stream_beat_t             temp_beat_reg;
    logic                                 temp_valid_reg;
    logic                                 temp_valid_next;

    logic                  store_in_to_out;
    logic                  store_in_to_temp;
    logic                  store_temp_to_out;

    // status of the currently selected output
    logic                  cur_valid;
    logic                  cur_ready;

    assign in_ready  = in_ready_reg;
    assign out_beat  = out_beat_reg;
    assign out_valid = out_valid_reg;

    assign cur_valid = out_valid_reg[select_reg];
    assign cur_ready = out_ready[select_reg];

    assign int_valid = in_valid && in_ready_reg;

    always_comb begin
        select_next = select_reg;
        frame_next  = frame_reg;

        if (frame_reg) begin
            // frame closes on the accepted last beat
            if (int_valid) begin
                frame_next = !in_beat.last;
            end
        end else if (route_en && in_valid && !cur_valid) begin
            // new frame, previous port has drained so the select may change
            frame_next  = 1'b1;
            select_next = route_sel;
        end

        in_ready_next = int_ready_early && frame_next;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            select_reg   <= '0;
            frame_reg    <= 1'b0;
            in_ready_reg <= 1'b0;
        end else begin
            select_reg   <= select_next;
            frame_reg    <= frame_next;
            in_ready_reg <= in_ready_next;
        end
    end

    // ready for next cycle when the output moves, or when neither register
    // will hold a beat that cannot leave
    assign int_ready_early = cur_ready ||
                             (!temp_valid_reg && (!cur_valid || !int_valid));

    always_comb begin
        out_valid_next    = out_valid_reg;
        temp_valid_next   = temp_valid_reg;
        store_in_to_out   = 1'b0;
        store_in_to_temp  = 1'b0;
        store_temp_to_out = 1'b0;

        if (int_ready_reg) begin
            if (cur_ready || !cur_valid) begin
                // output free or draining this cycle
                out_valid_next[select_reg] = int_valid;
                store_in_to_out            = 1'b1;
            end else begin
                // output stalled, park the beat
                temp_valid_next  = int_valid;
                store_in_to_temp = 1'b1;
            end
        end else if (cur_ready) begin
            // input closed, move the parked beat forward
            out_valid_next[select_reg] = temp_valid_reg;
            temp_valid_next            = 1'b0;
            store_temp_to_out          = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_reg  <= '0;
            temp_valid_reg <= 1'b0;
            int_ready_reg  <= 1'b0;
        end else begin
            out_valid_reg  <= out_valid_next;
            temp_valid_reg <= temp_valid_next;
            int_ready_reg  <= int_ready_early;
        end
    end

    // beat payload only moves with its valid
    always_ff @(posedge clk) begin
        if (store_in_to_out) begin
            out_beat_reg <= in_beat;
        end else if (store_temp_to_out) begin
            out_beat_reg <= temp_beat_reg;
        end

        if (store_in_to_temp) begin
            temp_beat_reg <= in_beat;
        end
    end

endmodule

//--- design/frame_route_decode.sv
// frame route decoder: strips the header byte and forwards or discards the payload
`timescale 1ns/1ps

module frame_route_decode (
    input  logic                      clk,
    input  logic                      rst,
    input  stream_pkg::stream_beat_t  s_beat,
    input  logic                      s_valid,
    output logic                      s_ready,
    output stream_pkg::stream_beat_t  dmx_beat,
    output logic                      dmx_valid,
    input  logic                      dmx_ready,
    output stream_pkg::port_sel_t     route_sel,
    output logic                      route_en
);

    stream_pkg::decode_state_t state_reg;
    stream_pkg::decode_state_t state_next;
    stream_pkg::port_sel_t     route_sel_reg;
    stream_pkg::port_sel_t     route_sel_next;
    logic                      s_xfer;

    assign s_xfer = s_valid && s_ready;

    // payload path is combinational, only valid is qualified by the state
    assign dmx_beat  = s_beat;
    assign dmx_valid = s_valid && (state_reg == stream_pkg::dec_forward);
    assign route_en  = (state_reg == stream_pkg::dec_forward);
    assign route_sel = route_sel_reg;

    always_comb begin
        state_next     = state_reg;
        route_sel_next = route_sel_reg;
        s_ready        = 1'b1;
        case (state_reg)
            stream_pkg::dec_header: begin
                // header with last set is a frame with no payload
                if (s_xfer && !s_beat.last) begin
                    if (s_beat.data[stream_pkg::hdr_drop_bit]) begin
                        state_next = stream_pkg::dec_discard;
                    end else begin
                        state_next     = stream_pkg::dec_forward;
                        route_sel_next = s_beat.data[$bits(stream_pkg::port_sel_t)-1:0];
                    end
                end
            end
            stream_pkg::dec_forward: begin
                s_ready = dmx_ready;
                if (s_xfer && s_beat.last) begin
                    state_next = stream_pkg::dec_header;
                end
            end
            stream_pkg::dec_discard: begin
                if (s_xfer && s_beat.last) begin
                    state_next = stream_pkg::dec_header;
                end
            end
            default: state_next = stream_pkg::dec_header;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg     <= stream_pkg::dec_header;
            route_sel_reg <= '0;
        end else begin
            state_reg     <= state_next;
            route_sel_reg <= route_sel_next;
        end
    end

endmodule

//--- design/port_fifo.sv
// per-port first-word-fall-through stream FIFO
`timescale 1ns/1ps

module port_fifo (
    input  logic                      clk,
    input  logic                      rst,
    input  stream_pkg::stream_beat_t  wr_beat,
    input  logic                      wr_valid,
    output logic                      wr_ready,
    output stream_pkg::stream_beat_t  rd_beat,
    output logic                      rd_valid,
    input  logic                      rd_ready
);

    // beat storage
    stream_pkg::stream_beat_t mem [stream_pkg::fifo_depth];

    logic [stream_pkg::fifo_addr_width-1:0] wr_ptr;
    logic [stream_pkg::fifo_addr_width-1:0] rd_ptr;
    // one extra bit so a full buffer is distinct from an empty one
    logic [stream_pkg::fifo_addr_width:0]   count;

    logic wr_xfer;
    logic rd_xfer;

    // depth is a power of two, so the top count bit means full
    assign wr_ready = !count[stream_pkg::fifo_addr_width];
    assign rd_valid = (count != '0);

    // oldest entry always shown at the read side
    assign rd_beat = mem[rd_ptr];

    assign wr_xfer = wr_valid && wr_ready;
    assign rd_xfer = rd_valid && rd_ready;

    always_ff @(posedge clk) begin
        if (wr_xfer) begin
            mem[wr_ptr] <= wr_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_xfer) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_xfer) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // occupancy holds when a write and a read meet
            case ({wr_xfer, rd_xfer})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- design/stream_pkg.sv
// stream switch package: beat struct, port select type, decoder states and sizes
package stream_pkg;

    // byte-wide stream payload
    localparam int data_width = 8;

    // switch outputs
    localparam int num_ports = 4;

    // per-port FIFO entries, kept a power of two
    localparam int fifo_depth = 8;
    localparam int fifo_addr_width = 3;

    // header bit that marks a frame for dropping
    localparam int hdr_drop_bit = 7;

    // destination port index taken from header bits 1:0
    typedef logic [$clog2(num_ports)-1:0] port_sel_t;

    // one beat as it travels next to a valid/ready pair
    typedef struct packed {
        logic [data_width-1:0] data;
        logic                  last;
        logic                  user;
    } stream_beat_t;

    // route decoder states
    typedef enum logic [1:0] {
        // waiting for a header byte
        dec_header,
        // payload goes to the demux
        dec_forward,
        // payload is accepted and thrown away
        dec_discard
    } decode_state_t;

endpackage

//--- design/stream_switch_top.sv
// stream frame switch: header decoder, four-port demux and per-port output FIFOs
`timescale 1ns/1ps

module stream_switch_top (
    input  logic                                                 clk,
    input  logic                                                 rst,
    input  stream_pkg::stream_beat_t                             s_beat,
    input  logic                                                 s_valid,
    output logic                                                 s_ready,
    output stream_pkg::stream_beat_t [stream_pkg::num_ports-1:0] m_beat,
    output logic [stream_pkg::num_ports-1:0]                     m_valid,
    input  logic [stream_pkg::num_ports-1:0]                     m_ready
);

    // decoder to demux
    stream_pkg::stream_beat_t          dmx_beat;
    logic                              dmx_valid;
    logic                              dmx_ready;
    stream_pkg::port_sel_t             route_sel;
    logic                              route_en;

    // demux to FIFOs, one beat bus shared by all ports
    stream_pkg::stream_beat_t          out_beat;
    logic [stream_pkg::num_ports-1:0]  out_valid;
    logic [stream_pkg::num_ports-1:0]  out_ready;

    frame_route_decode u_decode (
        .clk       (clk),
        .rst       (rst),
        .s_beat    (s_beat),
        .s_valid   (s_valid),
        .s_ready   (s_ready),
        .dmx_beat  (dmx_beat),
        .dmx_valid (dmx_valid),
        .dmx_ready (dmx_ready),
        .route_sel (route_sel),
        .route_en  (route_en)
    );

    axis_demux_4 u_demux (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (dmx_beat),
        .in_valid  (dmx_valid),
        .in_ready  (dmx_ready),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .route_en  (route_en),
        .route_sel (route_sel)
    );

    // one FIFO per output port
    for (genvar i = 0; i < stream_pkg::num_ports; i++) begin : g_port
        port_fifo u_fifo (
            .clk      (clk),
            .rst      (rst),
            .wr_beat  (out_beat),
            .wr_valid (out_valid[i]),
            .wr_ready (out_ready[i]),
            .rd_beat  (m_beat[i]),
            .rd_valid (m_valid[i]),
            .rd_ready (m_ready[i])
        );
    end

endmodule

//--- sources.f
design/stream_pkg.sv
design/frame_route_decode.sv
design/axis_demux_4.sv
design/port_fifo.sv
design/stream_switch_top.sv
bench/stream_switch_asserts.sv
bench/stream_switch_tb.sv
